// File: idStage.f
design/rvPkg.sv
design/instDecoder.sv
design/operandForward.sv
design/regFile.sv
design/idStage.sv
verif/idStageChecker.sv
verif/idStageTb.sv

// File: run.sh
#!/bin/sh
# Compile and run the ID stage testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --timing --assert -f idStage.f --top-module idStageTb \
    -o idStageSim > build.log 2>&1 &&
    ./obj_dir/idStageSim > sim.log 2>&1

grep -qx "Test passed" sim.log && echo "Simulation passed" ||
    { echo "Simulation failed, see build.log and sim.log"; exit 1; }

// File: verif/idStageTb.sv
`timescale 1ns/100ps

module idStageTb import rvPkg::*; ();

    localparam int unsigned seed      = 32'hcf7a;
    localparam int          numCycles = 2000;
    localparam int          timeout   = 100;        // Cycles allowed for the final drain

    logic    clk;
    logic    arstN;
    word_t   pc;
    word_t   inst;
    logic    exRdEn;
    regIdx_t exRdIdx;
    word_t   exRdData;
    logic    memRdEn;
    regIdx_t memRdIdx;
    word_t   memRdData;
    logic    wbEn;
    regIdx_t wbIdx;
    word_t   wbData;

    word_t   pcOut;
    aluOp_t  op;
    logic    rdEn;
    regIdx_t rdIdx;
    word_t   rs1Data;
    word_t   rs2Data;
    word_t   imm;

    int checks;
    int errors;
    int target;
    int waited;

    always #50 clk = ~clk;

    idStage dut0 (.*);

    idStageChecker checker0 (.*);

    // Small index set keeps forwarding and write-through hits frequent
    function automatic regIdx_t smallIdx();
        return regIdx_t'($urandom_range(0, 3));
    endfunction

    function automatic word_t randomInst();
        word_t      w;
        logic [6:0] opc;
        w = $urandom();
        case ($urandom_range(0, 9))
            0:       opc = opLui;
            1:       opc = opAuipc;
            2:       opc = opJal;
            3:       opc = opJalr;
            4:       opc = opBranch;
            5, 6:    opc = opRegImm;
            7, 8:    opc = opRegReg;
            default: opc = 7'($urandom());          // Mostly unknown opcodes
        endcase
        w[6:0]   = opc;
        w[11:7]  = smallIdx();
        w[19:15] = smallIdx();
        if (opc == opBranch || opc == opRegReg) begin
            w[24:20] = smallIdx();
        end
        if (opc == opJalr && $urandom_range(0, 3) != 0) begin
            w[14:12] = 3'b000;
        end
        return w;
    endfunction

    initial begin
        void'($urandom(seed));
        clk       = 1'b0;
        arstN     = 1'b0;
        pc        = '0;
        inst      = '0;
        exRdEn    = 1'b0;
        exRdIdx   = '0;
        exRdData  = '0;
        memRdEn   = 1'b0;
        memRdIdx  = '0;
        memRdData = '0;
        wbEn      = 1'b0;
        wbIdx     = '0;
        wbData    = '0;
        repeat (16) @(negedge clk);
        arstN = 1'b1;
        @(negedge clk);                             // One idle cycle checks reset values
        for (int i = 0; i < numCycles; i++) begin
            @(negedge clk);
            pc        = $urandom() & 32'hffff_fffc;
            inst      = randomInst();
            exRdEn    = 1'($urandom_range(0, 1));
            exRdIdx   = smallIdx();
            exRdData  = $urandom();
            memRdEn   = 1'($urandom_range(0, 1));
            memRdIdx  = smallIdx();
            memRdData = $urandom();
            wbEn      = 1'($urandom_range(0, 1));
            wbIdx     = smallIdx();
            wbData    = $urandom();
        end
        target = checks + 2;
        waited = 0;
        while (checks < target && waited < timeout) begin
            @(posedge clk);
            waited++;
        end
        if (checks < target) begin
            $display("Checker stopped comparing outputs before the end of the run");
            $display("Test failed");
        end else begin
            $display("Checks: %0d, value errors: %0d", checks, errors);
            if (errors == 0) begin
                $display("Test passed");
            end else begin
                $display("Test failed");
            end
        end
        $finish;
    end

endmodule : idStageTb

// File: verif/idStageChecker.sv
`timescale 1ns/100ps

module idStageChecker import rvPkg::*; (
    input  logic    clk,
    input  logic    arstN,
    input  word_t   pc,
    input  word_t   inst,
    input  logic    exRdEn,
    input  regIdx_t exRdIdx,
    input  word_t   exRdData,
    input  logic    memRdEn,
    input  regIdx_t memRdIdx,
    input  word_t   memRdData,
    input  logic    wbEn,
    input  regIdx_t wbIdx,
    input  word_t   wbData,
    input  word_t   pcOut,
    input  aluOp_t  op,
    input  logic    rdEn,
    input  regIdx_t rdIdx,
    input  word_t   rs1Data,
    input  word_t   rs2Data,
    input  word_t   imm,
    output int      checks,
    output int      errors
);

    word_t   shadow [numRegs];
    word_t   expPc;
    word_t   expRs1;
    word_t   expRs2;
    word_t   expImm;
    aluOp_t  expOp;
    logic    expRdEn;
    regIdx_t expRdIdx;
    logic    decRs1En;
    logic    decRs2En;
    logic    started = 1'b0;
    int      checkCount = 0;
    int      errorCount = 0;

    assign checks = checkCount;
    assign errors = errorCount;

    function automatic void refDecode(input word_t in, output aluOp_t dOp, output logic dRd,
                                      output logic dRs1, output logic dRs2, output word_t dImm);
        aluOp_t     aluTbl [8] = '{Add, Sll, Slt, Sltu, Xor, Srl, Or, And};
        aluOp_t     brTbl [8]  = '{Beq, Bne, Nop, Nop, Blt, Bge, Bltu, Bgeu};
        logic [2:0] f3;
        f3   = in[14:12];
        dOp  = Nop;
        dRd  = 1'b0;
        dRs1 = 1'b0;
        dRs2 = 1'b0;
        dImm = '0;
        case (in[6:0])
            opLui, opAuipc: begin
                dOp  = (in[6:0] == opLui) ? Lui : Auipc;
                dRd  = 1'b1;
                dImm = {in[31:12], 12'h000};
            end
            opJal: begin
                dOp  = Jal;
                dRd  = 1'b1;
                dImm = word_t'($signed({in[31], in[19:12], in[20], in[30:21], 1'b0}));
            end
            opJalr: begin
                if (f3 == 3'd0) begin
                    dOp  = Jalr;
                    dRd  = 1'b1;
                    dRs1 = 1'b1;
                    dImm = word_t'($signed(in[31:20]));
                end
            end
            opBranch: begin
                dOp = brTbl[f3];
                if (dOp != Nop) begin
                    dRs1 = 1'b1;
                    dRs2 = 1'b1;
                    dImm = word_t'($signed({in[31], in[7], in[30:25], in[11:8], 1'b0}));
                end
            end
            opRegImm, opRegReg: begin
                dOp  = aluTbl[f3];
                dRd  = 1'b1;
                dRs1 = 1'b1;
                if (in[30] && f3 == 3'd5) begin
                    dOp = Sra;
                end
                if (in[6:0] == opRegReg) begin
                    dRs2 = 1'b1;
                    if (in[30] && f3 == 3'd0) begin
                        dOp = Sub;
                    end
                end else if (f3[1:0] == 2'b01) begin
                    dImm = {27'd0, in[24:20]};              // Shift amount
                end else begin
                    dImm = word_t'($signed(in[31:20]));
                end
            end
            default: ;
        endcase
    endfunction

    function automatic word_t refOperand(input logic en, input regIdx_t idx);
        word_t rf;
        rf = (idx == '0) ? '0 : shadow[idx];
        if (wbEn && wbIdx == idx && idx != '0) begin
            rf = wbData;                                    // Write-through
        end
        if (!en) begin
            return '0;
        end
        if (exRdEn && exRdIdx == idx && idx != '0) begin
            return exRdData;
        end
        if (memRdEn && memRdIdx == idx && idx != '0) begin
            return memRdData;
        end
        return rf;
    endfunction

    always @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < numRegs; i++) begin
                shadow[i] = '0;
            end
            expPc    = '0;
            expOp    = Nop;
            expRdEn  = 1'b0;
            expRdIdx = '0;
            expRs1   = '0;
            expRs2   = '0;
            expImm   = '0;
        end else begin
            refDecode(inst, expOp, expRdEn, decRs1En, decRs2En, expImm);
            expPc    = pc;
            expRdIdx = expRdEn ? inst[11:7] : '0;
            expRs1   = refOperand(decRs1En, inst[19:15]);
            expRs2   = refOperand(decRs2En, inst[24:20]);
            if (wbEn && wbIdx != '0) begin
                shadow[wbIdx] = wbData;
            end
        end
        if (clk) begin
            started = 1'b1;
        end
    end

    task automatic compareValue(input string name, input word_t exp, input word_t act);
        if (exp !== act) begin
            errorCount++;
            $display("** Error %s: expected %h, actual %h at %0t", name, exp, act, $time);
        end
    endtask

    // Outputs settle after the rising edge, so compare half a cycle later
    always @(negedge clk) begin
        if (started) begin
            checkCount++;
            compareValue("decode.pcOut", expPc, pcOut);
            compareValue("decode.op", word_t'(expOp), word_t'(op));
            compareValue("decode.rdEn", word_t'(expRdEn), word_t'(rdEn));
            compareValue("decode.rdIdx", word_t'(expRdIdx), word_t'(rdIdx));
            compareValue("decode.imm", expImm, imm);
            compareValue("forward.rs1Data", expRs1, rs1Data);
            compareValue("forward.rs2Data", expRs2, rs2Data);
        end
    end

endmodule : idStageChecker

// File: design/idStage.sv
`timescale 1ns/100ps

module idStage import rvPkg::*; (
    input  logic    clk,
    input  logic    arstN,

    input  word_t   pc,
    input  word_t   inst,

    // Forwarding from end of EX and from non-load/store MEM
    input  logic    exRdEn,
    input  regIdx_t exRdIdx,
    input  word_t   exRdData,
    input  logic    memRdEn,
    input  regIdx_t memRdIdx,
    input  word_t   memRdData,

    input  logic    wbEn,
    input  regIdx_t wbIdx,
    input  word_t   wbData,

    // ID/EX register
    output word_t   pcOut,
    output aluOp_t  op,
    output logic    rdEn,
    output regIdx_t rdIdx,
    output word_t   rs1Data,
    output word_t   rs2Data,
    output word_t   imm
);

    aluOp_t  decOp;
    logic    decRdEn;
    regIdx_t decRdIdx;
    word_t   decImm;

    logic    rs1En;
    logic    rs2En;
    regIdx_t rs1Idx;
    regIdx_t rs2Idx;

    word_t   rs1RawData;
    word_t   rs2RawData;
    word_t   rs1FwdData;
    word_t   rs2FwdData;

    instDecoder decoder0 (
        .inst   (inst),
        .op     (decOp),
        .rdEn   (decRdEn),
        .rdIdx  (decRdIdx),
        .rs1En  (rs1En),
        .rs2En  (rs2En),
        .rs1Idx (rs1Idx),
        .rs2Idx (rs2Idx),
        .imm    (decImm)
    );

    regFile regFile0 (
        .clk     (clk),
        .arstN   (arstN),
        .rs1Idx  (rs1Idx),
        .rs2Idx  (rs2Idx),
        .rs1Data (rs1RawData),
        .rs2Data (rs2RawData),
        .wbEn    (wbEn),
        .wbIdx   (wbIdx),
        .wbData  (wbData)
    );

    operandForward fwdRs1 (
        .readEn    (rs1En),
        .srcIdx    (rs1Idx),
        .exRdEn    (exRdEn),
        .exRdIdx   (exRdIdx),
        .exRdData  (exRdData),
        .memRdEn   (memRdEn),
        .memRdIdx  (memRdIdx),
        .memRdData (memRdData),
        .rfData    (rs1RawData),
        .operand   (rs1FwdData)
    );

    operandForward fwdRs2 (
        .readEn    (rs2En),
        .srcIdx    (rs2Idx),
        .exRdEn    (exRdEn),
        .exRdIdx   (exRdIdx),
        .exRdData  (exRdData),
        .memRdEn   (memRdEn),
        .memRdIdx  (memRdIdx),
        .memRdData (memRdData),
        .rfData    (rs2RawData),
        .operand   (rs2FwdData)
    );

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            pcOut   <= '0;
            op      <= Nop;
            rdEn    <= 1'b0;
            rdIdx   <= '0;
            rs1Data <= '0;
            rs2Data <= '0;
            imm     <= '0;
        end else begin
            pcOut   <= pc;
            op      <= decOp;
            rdEn    <= decRdEn;
            rdIdx   <= decRdIdx;
            rs1Data <= rs1FwdData;
            rs2Data <= rs2FwdData;
            imm     <= decImm;
        end
    end

    // EX result for a read rs1 lands in ID/EX one cycle later
    assert property (@(posedge clk) disable iff (!arstN)
        (rs1En && exRdEn && exRdIdx == rs1Idx && rs1Idx != '0)
            |=> rs1Data == $past(exRdData))
        else $error("idStage: EX forward to rs1 lost");

endmodule : idStage

// File: design/regFile.sv
`timescale 1ns/100ps

module regFile import rvPkg::*; (
    input  logic    clk,
    input  logic    arstN,

    input  regIdx_t rs1Idx,
    input  regIdx_t rs2Idx,
    output word_t   rs1Data,
    output word_t   rs2Data,

    input  logic    wbEn,
    input  regIdx_t wbIdx,
    input  word_t   wbData
);

    word_t regs [numRegs];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < numRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (wbEn && wbIdx != '0) begin
            regs[wbIdx] <= wbData;
        end
    end

    // Same-cycle write is visible on the read port
    function automatic word_t readPort(input regIdx_t idx);
        if (idx == '0) begin
            return '0;
        end
        if (wbEn && wbIdx == idx) begin
            return wbData;
        end
        return regs[idx];
    endfunction

    always_comb begin
        rs1Data = readPort(rs1Idx);
        rs2Data = readPort(rs2Idx);
    end

    assert property (@(posedge clk) disable iff (!arstN) regs[0] == '0)
        else $error("regFile: x0 entry was written");

endmodule : regFile

// File: design/operandForward.sv
`timescale 1ns/100ps

module operandForward import rvPkg::*; (
    input  logic    readEn,
    input  regIdx_t srcIdx,

    input  logic    exRdEn,
    input  regIdx_t exRdIdx,
    input  word_t   exRdData,

    input  logic    memRdEn,            // MEM result other than load/store
    input  regIdx_t memRdIdx,
    input  word_t   memRdData,

    input  word_t   rfData,

    output word_t   operand
);

    logic exHit;
    logic memHit;

    assign exHit  = exRdEn  && (exRdIdx  == srcIdx) && (srcIdx != '0);
    assign memHit = memRdEn && (memRdIdx == srcIdx) && (srcIdx != '0);

    always_comb begin
        if (!readEn) begin
            operand = '0;
        end else if (exHit) begin
            operand = exRdData;         // Youngest result wins
        end else if (memHit) begin
            operand = memRdData;
        end else begin
            operand = rfData;
        end
    end

    always_comb begin
        if (!readEn) begin
            assert final (operand == '0)
                else $error("operandForward: disabled operand not zero");
        end
    end

endmodule : operandForward

// File: design/instDecoder.sv
`timescale 1ns/100ps

module instDecoder import rvPkg::*; (
    input  word_t   inst,

    output aluOp_t  op,
    output logic    rdEn,
    output regIdx_t rdIdx,
    output logic    rs1En,
    output logic    rs2En,
    output regIdx_t rs1Idx,
    output regIdx_t rs2Idx,
    output word_t   imm
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       funct7b5;

    word_t immI;
    word_t immU;
    word_t immJ;
    word_t immB;
    word_t immShamt;

    assign opcode   = inst[6:0];
    assign funct3   = inst[14:12];
    assign funct7b5 = inst[30];                     // Only funct7 bit used

    assign immI     = {{20{inst[31]}}, inst[31:20]};
    assign immU     = {inst[31:12], 12'b0};
    assign immJ     = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
    assign immB     = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    assign immShamt = {27'b0, inst[24:20]};         // Zero-extended shift amount

    always_comb begin
        op = Nop;
        case (opcode)
            opLui:   op = Lui;
            opAuipc: op = Auipc;
            opJal:   op = Jal;
            opJalr: begin
                if (funct3 == 3'b000) begin
                    op = Jalr;
                end
            end
            opBranch: begin
                case (funct3)
                    3'b000:  op = Beq;
                    3'b001:  op = Bne;
                    3'b100:  op = Blt;
                    3'b101:  op = Bge;
                    3'b110:  op = Bltu;
                    3'b111:  op = Bgeu;
                    default: op = Nop;              // 010 and 011 undefined
                endcase
            end
            opRegImm, opRegReg: begin
                case (funct3)
                    3'b000: begin
                        // SUB exists only in the register form
                        op = (opcode == opRegReg && funct7b5) ? Sub : Add;
                    end
                    3'b001:  op = Sll;
                    3'b010:  op = Slt;
                    3'b011:  op = Sltu;
                    3'b100:  op = Xor;
                    3'b101:  op = funct7b5 ? Sra : Srl;
                    3'b110:  op = Or;
                    default: op = And;
                endcase
            end
            default: op = Nop;                      // Loads, stores, FENCE, SYSTEM
        endcase
    end

    // Enables and immediate follow the format once op is known
    always_comb begin
        rdEn  = 1'b0;
        rs1En = 1'b0;
        rs2En = 1'b0;
        imm   = '0;
        if (op != Nop) begin
            case (opcode)
                opLui, opAuipc: begin
                    rdEn = 1'b1;
                    imm  = immU;
                end
                opJal: begin
                    rdEn = 1'b1;
                    imm  = immJ;
                end
                opJalr: begin
                    rdEn  = 1'b1;
                    rs1En = 1'b1;
                    imm   = immI;
                end
                opBranch: begin
                    rs1En = 1'b1;
                    rs2En = 1'b1;
                    imm   = immB;
                end
                opRegImm: begin
                    rdEn  = 1'b1;
                    rs1En = 1'b1;
                    imm   = (op inside {Sll, Srl, Sra}) ? immShamt : immI;
                end
                opRegReg: begin
                    rdEn  = 1'b1;
                    rs1En = 1'b1;
                    rs2En = 1'b1;
                end
                default: ;
            endcase
        end
    end

    assign rdIdx  = rdEn  ? inst[11:7]  : '0;
    assign rs1Idx = rs1En ? inst[19:15] : '0;
    assign rs2Idx = rs2En ? inst[24:20] : '0;

    // Every kept op has an enable, so an idle decode must be a clean NOP
    always_comb begin
        if (!rdEn && !rs1En && !rs2En) begin
            assert final (op == Nop && imm == '0)
                else $error("instDecoder: idle decode is not a clean NOP");
        end
    end

endmodule : instDecoder

// File: design/rvPkg.sv
package rvPkg;

    localparam int xlen    = 32;
    localparam int regIdxW = 5;
    localparam int numRegs = 32;

    // RV32I major opcodes kept by the decoder
    localparam logic [6:0] opLui    = 7'b0110111;
    localparam logic [6:0] opAuipc  = 7'b0010111;
    localparam logic [6:0] opJal    = 7'b1101111;
    localparam logic [6:0] opJalr   = 7'b1100111;
    localparam logic [6:0] opBranch = 7'b1100011;
    localparam logic [6:0] opRegImm = 7'b0010011;
    localparam logic [6:0] opRegReg = 7'b0110011;

    typedef logic [xlen-1:0]    word_t;     // Data, PC and immediate
    typedef logic [regIdxW-1:0] regIdx_t;

    typedef enum logic [4:0] {
        Nop,
        Lui,
        Auipc,
        Jal,
        Jalr,
        Beq,
        Bne,
        Blt,
        Bge,
        Bltu,
        Bgeu,
        Add,                                // Also ADDI
        Sub,
        Slt,
        Sltu,
        Xor,
        Or,
        And,
        Sll,
        Srl,
        Sra
    } aluOp_t;

endpackage : rvPkg
